// ==== hdl/nabp_geometry_pkg.sv ====
package nabp_geometry_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // projection geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // angle index width
    localparam int k_angle_length = 8;

    // sample index width within one projection line
    localparam int k_s_length = 5;

    // samples per projection line
    localparam int k_s_count = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data widths and latencies
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // raw unsigned sample from the host sinogram RAM
    localparam int k_data_length = 12;

    // signed ramp-filtered sample, 2*x0 - x1 - x2 fits in 14 bits
    localparam int k_filtered_length = 14;

    // hs_val in to filtered_val out
    localparam int k_filter_latency = 2;

    // host address to hs_val
    localparam int k_host_latency = 1;

endpackage

// ==== hdl/nabp_control_pkg.sv ====
package nabp_control_pkg;

    // number of rotating line buffers
    localparam int k_rotate = 3;

    // swap controller states
    typedef enum logic [2:0] {
        ready_s,
        fill_s,
        fill_and_work_1_s,
        fill_and_work_2_s,
        work_1_s,
        work_2_s
    } swap_state_t;

    // position in the buffer rotation table
    typedef enum logic [1:0] {
        sel_0,
        sel_1,
        sel_2
    } rotate_sel_t;

endpackage

// ==== hdl/nabp_ramp_filter.sv ====
`timescale 1ns/1ps

module nabp_ramp_filter
(
    input logic clk,
    input logic reset_n,
    input logic clear,
    input logic [nabp_geometry_pkg::k_data_length-1:0] hs_val,
    output logic signed [nabp_geometry_pkg::k_filtered_length-1:0] filtered_val
);

    import nabp_geometry_pkg::*;

    // counter wide enough to cover the host latency
    localparam int blank_w = $clog2(k_host_latency + 1);

    logic [blank_w-1:0] blank_cnt;
    logic blank;
    // sample history, x0 newest
    logic [k_data_length-1:0] x0;
    logic [k_data_length-1:0] x1;
    logic [k_data_length-1:0] x2;
    logic signed [k_filtered_length-1:0] x0_ext;
    logic signed [k_filtered_length-1:0] x1_ext;
    logic signed [k_filtered_length-1:0] x2_ext;
    logic signed [k_filtered_length-1:0] ramp_sum;

    // hs_val is stale until the first address of the new line returns
    assign blank = (blank_cnt != '0);

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            blank_cnt <= '0;
        end
        else if (clear)
        begin
            blank_cnt <= blank_w'(k_host_latency);
        end
        else if (blank)
        begin
            blank_cnt <= blank_cnt - 1'b1;
        end
    end

    // stage 1, history shift
    // clear zeroes the past so the line starts from silence
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            x0 <= '0;
            x1 <= '0;
            x2 <= '0;
        end
        else
        begin
            x0 <= blank ? '0 : hs_val;
            x1 <= x0;
            x2 <= x1;
        end
    end

    // zero-extend then treat as signed
    assign x0_ext = signed'(k_filtered_length'(x0));
    assign x1_ext = signed'(k_filtered_length'(x1));
    assign x2_ext = signed'(k_filtered_length'(x2));

    // ramp kernel  [2 -1 -1]
    assign ramp_sum = (x0_ext <<< 1) - x1_ext - x2_ext;

    // stage 2, output register
    always_ff @(posedge clk)
    begin
        filtered_val <= ramp_sum;
    end

endmodule

// ==== hdl/nabp_filtered_ram_swappable.sv ====
`timescale 1ns/1ps

module nabp_filtered_ram_swappable
#(
    parameter int s_count = nabp_geometry_pkg::k_s_count
)
(
    input logic clk,
    input logic reset_n,
    input logic fill_kick,
    input logic signed [nabp_geometry_pkg::k_filtered_length-1:0] filtered_val,
    input logic [nabp_geometry_pkg::k_s_length-1:0] pr0_s_val,
    output logic [nabp_geometry_pkg::k_s_length-1:0] hs_s_val,
    output logic fill_done,
    output logic signed [nabp_geometry_pkg::k_filtered_length-1:0] pr0_val
);

    import nabp_geometry_pkg::*;

    // address to filtered sample round trip
    localparam int wr_delay = k_host_latency + k_filter_latency;
    localparam int addr_w = $clog2(s_count);
    localparam logic [k_s_length-1:0] last_s = k_s_length'(s_count - 1);

    // one filtered projection line
    logic signed [k_filtered_length-1:0] line_mem [s_count];

    logic [k_s_length-1:0] fill_cnt;
    logic filling;
    // delayed copies of the host address
    logic [k_s_length-1:0] wr_addr_sr [wr_delay];
    logic [wr_delay-1:0] wr_valid_sr;
    logic [k_s_length-1:0] wr_addr;
    logic wr_en;

    assign hs_s_val = fill_cnt;
    assign wr_addr = wr_addr_sr[wr_delay-1];
    assign wr_en = wr_valid_sr[wr_delay-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fill side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // walk 0 .. s_count-1 once per kick
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            fill_cnt <= '0;
            filling <= 1'b0;
        end
        else if (fill_kick)
        begin
            fill_cnt <= '0;
            filling <= 1'b1;
        end
        else if (filling)
        begin
            if (fill_cnt == last_s)
                filling <= 1'b0;
            else
                fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // valid bit rides with the address
    always_ff @(posedge clk)
    begin
        if (reset_n)
            wr_valid_sr <= '0;
        else
            wr_valid_sr <= {wr_valid_sr[wr_delay-2:0], filling};
    end

    always_ff @(posedge clk)
    begin
        wr_addr_sr[0] <= fill_cnt;
        for (int i = 1; i < wr_delay; i++)
            wr_addr_sr[i] <= wr_addr_sr[i-1];
    end

    // raised one stage early so it lines up with the last write
    always_ff @(posedge clk)
    begin
        if (reset_n)
            fill_done <= 1'b1;
        else if (fill_kick)
            fill_done <= 1'b0;
        else if (wr_valid_sr[wr_delay-2] && (wr_addr_sr[wr_delay-2] == last_s))
            fill_done <= 1'b1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line RAM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // write port from the filter, registered read port for processing
    always_ff @(posedge clk)
    begin
        if (wr_en)
            line_mem[wr_addr[addr_w-1:0]] <= filtered_val;
        pr0_val <= line_mem[pr0_s_val[addr_w-1:0]];
    end

endmodule

// ==== hdl/nabp_filtered_ram_swap_control.sv ====
`timescale 1ns/1ps

module nabp_filtered_ram_swap_control
#(
    parameter int s_count = nabp_geometry_pkg::k_s_count,
    parameter int angle_length = nabp_geometry_pkg::k_angle_length
)
(
    input logic clk,
    input logic reset_n,
    // host side
    input logic [angle_length-1:0] hs_angle,
    input logic hs_has_next_angle,
    input logic hs_next_angle_ack,
    // from the ramp filter
    input logic signed [nabp_geometry_pkg::k_filtered_length-1:0] filtered_val,
    // processing side
    input logic [nabp_geometry_pkg::k_s_length-1:0] pr0_s_val,
    input logic [nabp_geometry_pkg::k_s_length-1:0] pr1_s_val,
    input logic pr_next_angle,
    input logic pr_done,
    // to host and filter
    output logic [nabp_geometry_pkg::k_s_length-1:0] hs_s_val,
    output logic hs_next_angle,
    output logic filter_clear,
    // to processing
    output logic [angle_length-1:0] pr0_angle,
    output logic [angle_length-1:0] pr1_angle,
    output logic pr0_angle_valid,
    output logic pr_next_angle_ack,
    output logic signed [nabp_geometry_pkg::k_filtered_length-1:0] pr0_val,
    output logic signed [nabp_geometry_pkg::k_filtered_length-1:0] pr1_val
);

    import nabp_geometry_pkg::*;
    import nabp_control_pkg::*;

    localparam int rot_w = $clog2(k_rotate);

    swap_state_t state;
    swap_state_t next_state;
    rotate_sel_t rotate_sel;
    logic rotate;
    logic fill_done;
    // angle of the line now being filled
    logic [angle_length-1:0] fill_angle;
    logic fill_angle_valid;
    // buffer roles for the current rotation
    logic [rot_w-1:0] fill_idx;
    logic [rot_w-1:0] work_idx;
    logic [rot_w-1:0] shift_idx;
    // per-buffer wiring
    logic sw_fill_kick [k_rotate];
    logic sw_fill_done [k_rotate];
    logic [k_s_length-1:0] sw_hs_s_val [k_rotate];
    logic [k_s_length-1:0] sw_rd_s_val [k_rotate];
    logic signed [k_filtered_length-1:0] sw_pr_val [k_rotate];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // state and rotation step together
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state <= ready_s;
            rotate_sel <= sel_0;
        end
        else
        begin
            state <= next_state;
            if (rotate)
            begin
                case (rotate_sel)
                    sel_0: rotate_sel <= sel_1;
                    sel_1: rotate_sel <= sel_2;
                    default: rotate_sel <= sel_0;
                endcase
            end
        end
    end

    // rotation conditions, Mealy outputs
    always_comb
    begin
        rotate = 1'b0;
        hs_next_angle = 1'b0;
        pr_next_angle_ack = 1'b0;
        case (state)
            // host starts the first line by acking
            ready_s:
                if (hs_next_angle_ack)
                    rotate = 1'b1;
            // first line only, nothing to wait for on processing
            fill_s:
                if (fill_done)
                begin
                    hs_next_angle = 1'b1;
                    if (hs_next_angle_ack)
                    begin
                        rotate = 1'b1;
                        pr_next_angle_ack = 1'b1;
                    end
                end
            // both sides must be ready
            // without a next angle the last line is pushed through anyway
            fill_and_work_1_s, fill_and_work_2_s:
                if (fill_done && pr_next_angle)
                begin
                    hs_next_angle = hs_has_next_angle;
                    if (!hs_has_next_angle || hs_next_angle_ack)
                    begin
                        rotate = 1'b1;
                        pr_next_angle_ack = 1'b1;
                    end
                end
            // drain, move last line into pr1
            work_1_s:
                if (pr_next_angle)
                begin
                    rotate = 1'b1;
                    pr_next_angle_ack = 1'b1;
                end
            default:
                rotate = 1'b0;
        endcase
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (rotate)
                    next_state = fill_s;
            fill_s:
                if (rotate)
                    next_state = fill_and_work_1_s;
            fill_and_work_1_s, fill_and_work_2_s:
                if (rotate)
                begin
                    if (hs_has_next_angle)
                        next_state = fill_and_work_2_s;
                    else
                        next_state = work_1_s;
                end
            work_1_s:
                if (rotate)
                    next_state = work_2_s;
            work_2_s:
                if (pr_done)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // angle pipeline, fill -> pr0 -> pr1
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            fill_angle_valid <= 1'b0;
            pr0_angle_valid <= 1'b0;
        end
        else if (rotate)
        begin
            fill_angle_valid <= hs_has_next_angle;
            pr0_angle_valid <= fill_angle_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rotate)
        begin
            fill_angle <= hs_angle;
            pr0_angle <= fill_angle;
            pr1_angle <= pr0_angle;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // multiplexing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    //  rotate_sel    0  1  2
    //  fill (host)   0  2  1
    //  work (pr0)    1  0  2
    //  shift (pr1)   2  1  0
    always_comb
    begin
        case (rotate_sel)
            sel_1:
            begin
                fill_idx = rot_w'(2);
                work_idx = rot_w'(0);
                shift_idx = rot_w'(1);
            end
            sel_2:
            begin
                fill_idx = rot_w'(1);
                work_idx = rot_w'(2);
                shift_idx = rot_w'(0);
            end
            default:
            begin
                fill_idx = rot_w'(0);
                work_idx = rot_w'(1);
                shift_idx = rot_w'(2);
            end
        endcase
    end

    assign hs_s_val = sw_hs_s_val[fill_idx];
    assign fill_done = sw_fill_done[fill_idx];
    assign pr0_val = sw_pr_val[work_idx];
    assign pr1_val = sw_pr_val[shift_idx];
    // every rotation restarts the filter history
    assign filter_clear = rotate;

    always_comb
    begin
        for (int i = 0; i < k_rotate; i++)
        begin
            // shift buffer is the next one to fill
            sw_fill_kick[i] = rotate && (rot_w'(i) == shift_idx);
            if (rot_w'(i) == work_idx)
                sw_rd_s_val[i] = pr0_s_val;
            else if (rot_w'(i) == shift_idx)
                sw_rd_s_val[i] = pr1_s_val;
            else
                sw_rd_s_val[i] = '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // buffer instances
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar g = 0; g < k_rotate; g++)
    begin : gen_sw
        nabp_filtered_ram_swappable
        #(
            .s_count(s_count)
        )
        u_sw
        (
            .clk(clk),
            .reset_n(reset_n),
            .fill_kick(sw_fill_kick[g]),
            .filtered_val(filtered_val),
            .pr0_s_val(sw_rd_s_val[g]),
            .hs_s_val(sw_hs_s_val[g]),
            .fill_done(sw_fill_done[g]),
            .pr0_val(sw_pr_val[g])
        );
    end

endmodule

// ==== hdl/nabp_filtered_ram.sv ====
`timescale 1ns/1ps

module nabp_filtered_ram
#(
    parameter int s_count = nabp_geometry_pkg::k_s_count,
    parameter int angle_length = nabp_geometry_pkg::k_angle_length
)
(
    input logic clk,
    input logic reset_n,
    // host side
    input logic [angle_length-1:0] hs_angle,
    input logic hs_has_next_angle,
    input logic hs_next_angle_ack,
    input logic [nabp_geometry_pkg::k_data_length-1:0] hs_val,
    // processing side
    input logic [nabp_geometry_pkg::k_s_length-1:0] pr0_s_val,
    input logic [nabp_geometry_pkg::k_s_length-1:0] pr1_s_val,
    input logic pr_next_angle,
    input logic pr_done,
    // to host
    output logic [nabp_geometry_pkg::k_s_length-1:0] hs_s_val,
    output logic hs_next_angle,
    // to processing
    output logic [angle_length-1:0] pr0_angle,
    output logic [angle_length-1:0] pr1_angle,
    output logic pr0_angle_valid,
    output logic pr_next_angle_ack,
    output logic signed [nabp_geometry_pkg::k_filtered_length-1:0] pr0_val,
    output logic signed [nabp_geometry_pkg::k_filtered_length-1:0] pr1_val
);

    import nabp_geometry_pkg::*;

    logic signed [k_filtered_length-1:0] filtered_val;
    logic filter_clear;

    // FIR beside the swap control, fed straight from the host RAM
    nabp_ramp_filter u_filter
    (
        .clk(clk),
        .reset_n(reset_n),
        .clear(filter_clear),
        .hs_val(hs_val),
        .filtered_val(filtered_val)
    );

    // three rotating line buffers
    nabp_filtered_ram_swap_control
    #(
        .s_count(s_count),
        .angle_length(angle_length)
    )
    u_swap_control
    (
        .clk(clk),
        .reset_n(reset_n),
        .hs_angle(hs_angle),
        .hs_has_next_angle(hs_has_next_angle),
        .hs_next_angle_ack(hs_next_angle_ack),
        .filtered_val(filtered_val),
        .pr0_s_val(pr0_s_val),
        .pr1_s_val(pr1_s_val),
        .pr_next_angle(pr_next_angle),
        .pr_done(pr_done),
        .hs_s_val(hs_s_val),
        .hs_next_angle(hs_next_angle),
        .filter_clear(filter_clear),
        .pr0_angle(pr0_angle),
        .pr1_angle(pr1_angle),
        .pr0_angle_valid(pr0_angle_valid),
        .pr_next_angle_ack(pr_next_angle_ack),
        .pr0_val(pr0_val),
        .pr1_val(pr1_val)
    );

endmodule

// ==== tests/nabp_filtered_ram_tb.sv ====
`timescale 1ns/1ps

module nabp_filtered_ram_tb;

    import nabp_geometry_pkg::*;

    localparam int n_angles = 5;
    localparam int cycle_limit = n_angles * (k_s_count + 60) * 4;
    // cycles the host sits on its first request
    localparam int host_stall = 20;

    logic clk;
    logic reset_n;
    logic [k_angle_length-1:0] hs_angle;
    logic hs_has_next_angle;
    logic hs_next_angle_ack;
    logic [k_data_length-1:0] hs_val;
    logic [k_s_length-1:0] pr0_s_val;
    logic [k_s_length-1:0] pr1_s_val;
    logic pr_next_angle;
    logic pr_done;
    logic [k_s_length-1:0] hs_s_val;
    logic hs_next_angle;
    logic [k_angle_length-1:0] pr0_angle;
    logic [k_angle_length-1:0] pr1_angle;
    logic pr0_angle_valid;
    logic pr_next_angle_ack;
    logic signed [k_filtered_length-1:0] pr0_val;
    logic signed [k_filtered_length-1:0] pr1_val;

    // host sinogram RAM, one line per angle
    logic [k_data_length-1:0] line_data [n_angles][k_s_count];
    int checks;
    int errors;
    int cycle_cnt;

    nabp_filtered_ram
    #(
        .s_count(k_s_count),
        .angle_length(k_angle_length)
    )
    UUT
    (
        .clk(clk),
        .reset_n(reset_n),
        .hs_angle(hs_angle),
        .hs_has_next_angle(hs_has_next_angle),
        .hs_next_angle_ack(hs_next_angle_ack),
        .hs_val(hs_val),
        .pr0_s_val(pr0_s_val),
        .pr1_s_val(pr1_s_val),
        .pr_next_angle(pr_next_angle),
        .pr_done(pr_done),
        .hs_s_val(hs_s_val),
        .hs_next_angle(hs_next_angle),
        .pr0_angle(pr0_angle),
        .pr1_angle(pr1_angle),
        .pr0_angle_valid(pr0_angle_valid),
        .pr_next_angle_ack(pr_next_angle_ack),
        .pr0_val(pr0_val),
        .pr1_val(pr1_val)
    );

    always #4 clk = ~clk;

    // angle number presented for line i
    function automatic logic [k_angle_length-1:0] angle_of(input int i);
        return k_angle_length'(17 + 23 * i);
    endfunction

    // ramp kernel [2 -1 -1] with zero history before sample 0
    function automatic logic [15:0] ramp_ref(input int line, input int s);
        int acc;
        acc = 2 * int'(line_data[line][s]);
        if (s >= 1)
            acc = acc - int'(line_data[line][s-1]);
        if (s >= 2)
            acc = acc - int'(line_data[line][s-2]);
        return {2'b00, k_filtered_length'(acc)};
    endfunction

    task automatic compare_hex(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        checks++;
        assert (got === expected)
        else
        begin
            errors++;
            $display("[FAIL] %s got %h expected %h at cycle %0d", name, got, expected,
                     cycle_cnt);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("error at cycle %0d: %s", cycle_cnt, what);
        end
    endtask

    task automatic end_run(input bit timed_out);
        if (timed_out)
        begin
            errors++;
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    // watchdog
    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit)
            end_run(1'b1);
    end

    initial
    begin
        int host_line;
        int next_idx;
        int fill_exp;
        int pr0_exp;
        int pr1_exp;
        int fill_pos;
        int phase;
        int rd_pos;
        int rd_addr;
        int rd_addr_d;
        int host_wait;
        int proc_wait;
        int pr0_lines;
        int pr1_lines;
        bit in_ready;
        bit rot;
        bit rot_acked;
        bit rd_chk;
        bit rd_chk_d;
        bit finished;
        bit ack_nxt;
        bit prn_nxt;
        bit done_nxt;
        logic [k_data_length-1:0] val_nxt;

        clk = 1'b0;
        reset_n = 1'b1;
        hs_angle = angle_of(0);
        hs_has_next_angle = 1'b1;
        hs_next_angle_ack = 1'b0;
        hs_val = '0;
        pr0_s_val = '0;
        pr1_s_val = '0;
        pr_next_angle = 1'b0;
        pr_done = 1'b0;
        checks = 0;
        errors = 0;
        cycle_cnt = 0;
        host_line = -1;
        next_idx = 0;
        fill_exp = -1;
        pr0_exp = -1;
        pr1_exp = -1;
        fill_pos = k_s_count;
        phase = 0;
        rd_pos = 0;
        rd_addr = 0;
        rd_addr_d = 0;
        host_wait = host_stall;
        proc_wait = 30;
        pr0_lines = 0;
        pr1_lines = 0;
        in_ready = 1'b1;
        rd_chk = 1'b0;
        rd_chk_d = 1'b0;
        finished = 1'b0;
        prn_nxt = 1'b0;

        void'($urandom(28724));
        for (int i = 0; i < n_angles; i++)
            for (int s = 0; s < k_s_count; s++)
                line_data[i][s] = k_data_length'($urandom);

        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b0;

        // idle after reset with nothing requested yet
        repeat (4)
        begin
            @(negedge clk);
            compare_hex("hs_next_angle", 16'(hs_next_angle), 16'h0);
            compare_hex("pr_next_angle_ack", 16'(pr_next_angle_ack), 16'h0);
            compare_hex("pr0_angle_valid", 16'(pr0_angle_valid), 16'h0);
        end

        while (!finished)
        begin
            @(negedge clk);
            done_nxt = 1'b0;

            // host RAM answers the current address next cycle
            val_nxt = (host_line >= 0) ? line_data[host_line][hs_s_val] : '0;

            if (fill_pos < k_s_count)
            begin
                compare_hex("hs_s_val", 16'(hs_s_val), 16'(fill_pos));
                fill_pos++;
            end

            // data for the addresses the DUT sampled at the last edge
            if (rd_chk_d)
            begin
                compare_hex("pr0_angle_valid", 16'(pr0_angle_valid), 16'(pr0_exp >= 0));
                if (pr0_exp >= 0)
                begin
                    compare_hex("pr0_val", {2'b00, pr0_val}, ramp_ref(pr0_exp, rd_addr_d));
                    compare_hex("pr0_angle", 16'(pr0_angle), 16'(angle_of(pr0_exp)));
                end
                if (pr1_exp >= 0)
                begin
                    compare_hex("pr1_val", {2'b00, pr1_val},
                                ramp_ref(pr1_exp, k_s_count - 1 - rd_addr_d));
                    compare_hex("pr1_angle", 16'(pr1_angle), 16'(angle_of(pr1_exp)));
                end
            end
            // address issued last cycle is sampled at the coming edge
            rd_chk_d = rd_chk;
            rd_addr_d = rd_addr;

            rot = pr_next_angle_ack || (in_ready && hs_next_angle_ack);
            rot_acked = rot && hs_next_angle_ack;

            // processing side
            rd_chk = 1'b0;
            if (phase == 1)
            begin
                if (rd_pos < k_s_count)
                begin
                    rd_addr = rd_pos;
                    rd_chk = 1'b1;
                    rd_pos++;
                end
                else
                begin
                    phase = 2;
                    if (pr0_exp >= 0)
                        pr0_lines++;
                    if (pr1_exp >= 0)
                        pr1_lines++;
                end
            end
            else if (phase == 2)
            begin
                if (pr0_exp == 2 && proc_wait > 0)
                begin
                    // processing holds back so nothing may rotate
                    check_true(!pr_next_angle_ack, "ack without processing request");
                    compare_hex("pr0_angle", 16'(pr0_angle), 16'(angle_of(2)));
                    proc_wait--;
                end
                else if (pr0_exp < 0)
                begin
                    done_nxt = 1'b1;
                    phase = 0;
                end
                else
                begin
                    prn_nxt = 1'b1;
                end
            end

            if (pr_done)
                finished = 1'b1;

            if (rot)
            begin
                in_ready = 1'b0;
                pr1_exp = pr0_exp;
                pr0_exp = fill_exp;
                fill_exp = rot_acked ? next_idx : -1;
                if (rot_acked)
                    next_idx++;
                host_line = fill_exp;
                fill_pos = 0;
                prn_nxt = 1'b0;
                if (pr0_exp >= 0 || pr1_exp >= 0)
                begin
                    phase = 1;
                    rd_pos = 0;
                end
            end

            // host strobes ack once per request
            ack_nxt = 1'b0;
            if (hs_next_angle_ack)
                ack_nxt = 1'b0;
            else if (in_ready)
                ack_nxt = 1'b1;
            else if (next_idx == 1 && host_wait > 0
                     && (hs_next_angle || host_wait < host_stall))
            begin
                // once raised the request has to stay up while the host waits
                check_true(hs_next_angle, "hs_next_angle dropped while host stalls");
                check_true(!pr_next_angle_ack, "rotation while host stalls");
                compare_hex("pr0_angle_valid", 16'(pr0_angle_valid), 16'h0);
                host_wait--;
            end
            else if (hs_next_angle && next_idx < n_angles)
            begin
                ack_nxt = 1'b1;
            end

            @(posedge clk);
            #1;
            hs_val = val_nxt;
            hs_next_angle_ack = ack_nxt;
            hs_has_next_angle = (next_idx < n_angles);
            hs_angle = (next_idx < n_angles) ? angle_of(next_idx) : '0;
            pr0_s_val = k_s_length'(rd_addr);
            // pr1 walks the line backwards
            pr1_s_val = k_s_length'(k_s_count - 1 - rd_addr);
            pr_next_angle = prn_nxt;
            pr_done = done_nxt;
        end

        // requests that any working state would answer
        hs_has_next_angle = 1'b1;
        hs_angle = angle_of(n_angles);
        pr_next_angle = 1'b1;
        repeat (20)
        begin
            @(negedge clk);
            check_true(!hs_next_angle, "hs_next_angle raised after pr_done");
            check_true(!pr_next_angle_ack, "pr_next_angle_ack raised after pr_done");
        end

        // only the ready state starts a fill on a bare ack
        @(posedge clk);
        #1;
        hs_next_angle_ack = 1'b1;
        @(posedge clk);
        #1;
        hs_next_angle_ack = 1'b0;
        @(negedge clk);
        compare_hex("hs_s_val", 16'(hs_s_val), 16'h0);

        compare_hex("pr0 lines read", 16'(pr0_lines), 16'(n_angles));
        compare_hex("pr1 lines read", 16'(pr1_lines), 16'(n_angles));
        check_true(host_wait == 0 && proc_wait == 0, "a stall window was never reached");
        end_run(1'b0);
    end

endmodule

// ==== nabp_filtered_ram.f ====
hdl/nabp_geometry_pkg.sv
hdl/nabp_control_pkg.sv
hdl/nabp_ramp_filter.sv
hdl/nabp_filtered_ram_swappable.sv
hdl/nabp_filtered_ram_swap_control.sv
hdl/nabp_filtered_ram.sv
tests/nabp_filtered_ram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the filtered projection buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module nabp_filtered_ram_tb \
    -f nabp_filtered_ram.f \
    -o nabp_filtered_ram_sim

./obj_dir/nabp_filtered_ram_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
